//--- dv/erx_sva.sv
`timescale 1ns/1ps
`default_nettype none

module erx_sva
(
   input wire rxlclk_p,
   input wire arst_n,
   input wire wr_en,                     // FIFO side
   input wire full,
   input wire rd_en,
   input wire empty,
   input wire wb_ack,                    // Config side
   input wire rx_valid,
   input wire mmu_valid
);

   a_no_write_full: assert property (@(posedge rxlclk_p) disable iff (!arst_n)
      wr_en |-> !full) else $error("FIFO written while full");

   a_no_read_empty: assert property (@(posedge rxlclk_p) disable iff (!arst_n)
      rd_en |-> !empty) else $error("FIFO read while empty");

   // Single-cycle acknowledge
   a_ack_pulse: assert property (@(posedge rxlclk_p) disable iff (!arst_n)
      wb_ack |=> !wb_ack) else $error("wb_ack held longer than one cycle");

   a_mmu_follow: assert property (@(posedge rxlclk_p) disable iff (!arst_n)
      rx_valid |=> mmu_valid) else $error("mmu_valid missing after rx_valid");

endmodule

bind erx_fifo erx_sva u_fifo_sva (
   .rxlclk_p (rxlclk_p), .arst_n (arst_n),
   .wr_en (wr_en), .full (full), .rd_en (rd_en), .empty (empty),
   .wb_ack (1'b0), .rx_valid (1'b0), .mmu_valid (1'b0));

bind erx_cfg_mmu erx_sva u_cfg_sva (
   .rxlclk_p (rxlclk_p), .arst_n (arst_n),
   .wr_en (1'b0), .full (1'b0), .rd_en (1'b0), .empty (1'b1),
   .wb_ack (wb_ack), .rx_valid (rx_valid), .mmu_valid (mmu_valid));

`default_nettype wire

//--- dv/erx_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "erx_consts.svh"

module erx_tb;

   import erx_pkg::*;

   localparam int N_FRAMES    = 400;
   localparam int WATCHDOG_NS = N_FRAMES * 20 * 20 + 20000; // Frames x cycles x period + slack

   logic       rxlclk_p;
   logic       arst_n;
   logic       rx_frame;
   logic [7:0] rx_data;
   logic       rx_wr_wait;
   logic       rx_rd_wait;
   wb_req_t    wb_req;
   data_t      wb_dat_r;
   logic       wb_ack;
   logic [2:0] q_rd_en;                  // 0 write, 1 read request, 2 read response
   wire  [2:0] q_empty;
   emesh_pkt_t wr_rd_data;
   emesh_pkt_t rq_rd_data;
   emesh_pkt_t rr_rd_data;

   // Reference model state
   logic       model_enable;
   logic       model_mmu;
   page_t      model_tbl [`ERX_MMU_ENTRIES];
   emesh_pkt_t exp_wr [$];
   emesh_pkt_t exp_rq [$];
   emesh_pkt_t exp_rr [$];
   int         mismatch_cnt;
   int         fail_cnt;
   int         stall_cnt [3];            // Per-reader stall length left
   logic       stall_all;                // All readers held off
   logic       wait_seen;

   initial
      rxlclk_p = 1'b0;
   always #10 rxlclk_p = ~rxlclk_p;      // 20 ns period

   erx u_dut (
      .rxlclk_p (rxlclk_p), .arst_n (arst_n), .rx_frame (rx_frame), .rx_data (rx_data),
      .rx_wr_wait (rx_wr_wait), .rx_rd_wait (rx_rd_wait),
      .wb_req (wb_req), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
      .wr_rd_en (q_rd_en[0]), .wr_empty (q_empty[0]), .wr_rd_data (wr_rd_data),
      .rq_rd_en (q_rd_en[1]), .rq_empty (q_empty[1]), .rq_rd_data (rq_rd_data),
      .rr_rd_en (q_rd_en[2]), .rr_empty (q_empty[2]), .rr_rd_data (rr_rd_data));

   function automatic emesh_pkt_t random_pkt();
      emesh_pkt_t p;
      p.write    = 1'($urandom);
      p.datamode = 2'($urandom);
      p.ctrlmode = 4'($urandom);
      p.dstaddr  = $urandom;
      p.data     = $urandom;
      p.srcaddr  = $urandom;
      if (p.write && ($urandom % 4 == 0))
         p.dstaddr[31:20] = `ERX_RR_ID;  // Some read responses
      return p;
   endfunction

   // Queue choice from the routing rule
   function automatic int pick_queue(input emesh_pkt_t p);
      if (!p.write)
         return 1;
      if (p.dstaddr[31:20] == `ERX_RR_ID)
         return 2;
      return 0;
   endfunction

   function automatic int exp_count(input int qi);
      case (qi)
         0:       return exp_wr.size();
         1:       return exp_rq.size();
         default: return exp_rr.size();
      endcase
   endfunction

   function automatic emesh_pkt_t head_word(input int qi);
      case (qi)
         0:       return wr_rd_data;
         1:       return rq_rd_data;
         default: return rr_rd_data;
      endcase
   endfunction

   task automatic model_accept(input emesh_pkt_t p);
      emesh_pkt_t t;
      t = p;
      if (model_mmu)
         t.dstaddr[31:20] = model_tbl[p.dstaddr[31:28]]; // Page swap, low 20 bits kept
      if (model_enable)
      begin
         case (pick_queue(t))
            0:       exp_wr.push_back(t);
            1:       exp_rq.push_back(t);
            default: exp_rr.push_back(t);
         endcase
      end
   endtask

   task automatic pop_and_check(input int qi);
      emesh_pkt_t want;
      emesh_pkt_t got;
      got = head_word(qi);
      assert (exp_count(qi) != 0)
      else
      begin
         fail_cnt++;
         $display("Queue %0d delivered a transaction that was never sent", qi);
      end
      if (exp_count(qi) != 0)
      begin
         case (qi)
            0:       want = exp_wr.pop_front();
            1:       want = exp_rq.pop_front();
            default: want = exp_rr.pop_front();
         endcase
         assert (got === want)
         else
         begin
            mismatch_cnt++;
            $display("Mismatch at %0t: queue %0d got %h, expected %h", $time, qi, got, want);
         end
      end
   endtask

   // One bus cycle, returns at a falling edge with the bus idle
   task automatic wb_access(input logic we, input int adr, input data_t dat_w,
                            output data_t dat_r);
      int guard;
      guard         = 0;
      wb_req.cyc    = 1'b1;
      wb_req.stb    = 1'b1;
      wb_req.we     = we;
      wb_req.adr    = wb_adr_t'(adr);
      wb_req.dat_w  = dat_w;
      @(negedge rxlclk_p);
      while (!wb_ack && guard < 8)
      begin
         @(negedge rxlclk_p);
         guard++;
      end
      assert (wb_ack)
      else
      begin
         fail_cnt++;
         $display("Wishbone access to word %0d got no acknowledge", adr);
      end
      dat_r  = wb_dat_r;
      wb_req = '0;
      @(negedge rxlclk_p);
   endtask

   task automatic cfg_write(input int adr, input data_t dat);
      data_t unused;
      wb_access(1'b1, adr, dat, unused);
      if (adr == `ERX_REG_CTRL)
      begin
         model_enable = dat[0];
         model_mmu    = dat[1];
      end
      else if (adr >= `ERX_REG_TABLE_BASE)
         model_tbl[adr - `ERX_REG_TABLE_BASE] = dat[11:0]; // Only 12 bits stored
   endtask

   task automatic cfg_check(input int adr, input data_t want);
      data_t got;
      wb_access(1'b0, adr, '0, got);
      assert (got === want)
      else
      begin
         mismatch_cnt++;
         $display("Mismatch at %0t: register %0d read %h, expected %h", $time, adr, got, want);
      end
   endtask

   // Starts and ends at a falling edge
   task automatic send_bytes(input emesh_pkt_t p, input int n_bytes);
      logic [95:0] body;
      logic [7:0]  ctrl_byte;
      body      = {p.dstaddr, p.data, p.srcaddr}; // MSB first on the link
      ctrl_byte = {p.write, p.datamode, 1'($urandom), p.ctrlmode};
      for (int b = 0; b < n_bytes; b++)
      begin
         rx_frame = 1'b1;
         if (b == 0)
            rx_data = ctrl_byte;
         else
            rx_data = body[95 - 8*(b-1) -: 8];
         @(negedge rxlclk_p);
      end
   endtask

   task automatic run_frames(input int count);
      emesh_pkt_t p;
      int         gap;
      logic       after_abort;
      after_abort = 1'b0;
      for (int n = 0; n < count; n++)
      begin
         p   = random_pkt();
         gap = $urandom % 4;
         if (after_abort && gap == 0)
            gap = 1;                     // Frame drops before a retry
         repeat (gap)
         begin
            rx_frame = 1'b0;
            @(negedge rxlclk_p);
         end
         while (p.write ? rx_wr_wait : rx_rd_wait)
         begin
            rx_frame = 1'b0;             // Hold off per link wait
            @(negedge rxlclk_p);
         end
         after_abort = ($urandom % 20 == 0);
         if (after_abort)
            send_bytes(p, 1 + $urandom % (`ERX_FRAME_BYTES - 1));
         else
         begin
            send_bytes(p, `ERX_FRAME_BYTES);
            model_accept(p);
         end
      end
      rx_frame = 1'b0;
      rx_data  = '0;
   endtask

   task automatic stall_phase();
      repeat (300) @(negedge rxlclk_p);
      stall_all = 1'b1;
      repeat (800) @(negedge rxlclk_p);
      stall_all = 1'b0;
   endtask

   task automatic wait_drain();
      int guard;
      guard = 0;
      while (exp_count(0) + exp_count(1) + exp_count(2) != 0 && guard < 4000)
      begin
         @(negedge rxlclk_p);
         guard++;
      end
      repeat (8) @(negedge rxlclk_p);
      assert (exp_count(0) + exp_count(1) + exp_count(2) == 0 && q_empty == 3'b111)
      else
      begin
         fail_cnt++;
         $display("Queues did not drain: %0d transactions missing, empty flags %b",
                  exp_count(0) + exp_count(1) + exp_count(2), q_empty);
      end
   endtask

   // Queue readers, random pace with stall phases
   always @(negedge rxlclk_p)
   begin
      if (rx_wr_wait || rx_rd_wait)
         wait_seen = 1'b1;
      for (int qi = 0; qi < 3; qi++)
      begin
         q_rd_en[qi] = 1'b0;
         if (arst_n && !stall_all)
         begin
            if (stall_cnt[qi] > 0)
               stall_cnt[qi]--;
            else if ($urandom % 150 == 0)
               stall_cnt[qi] = 40 + $urandom % 40;
            else if (!q_empty[qi] && ($urandom % 4 != 0))
            begin
               q_rd_en[qi] = 1'b1;
               pop_and_check(qi);        // Head word is stable here
            end
         end
      end
   end

   initial
   begin
      data_t ent;
      void'($urandom(32'heab76440));
      arst_n       = 1'b0;
      rx_frame     = 1'b0;
      rx_data      = '0;
      wb_req       = '0;
      q_rd_en      = '0;
      stall_all    = 1'b0;
      wait_seen    = 1'b0;
      model_enable = 1'b0;
      model_mmu    = 1'b0;
      mismatch_cnt = 0;
      fail_cnt     = 0;
      for (int i = 0; i < `ERX_MMU_ENTRIES; i++)
         model_tbl[i] = '0;
      for (int i = 0; i < 3; i++)
         stall_cnt[i] = 0;
      repeat (3) @(negedge rxlclk_p);
      arst_n = 1'b1;
      @(negedge rxlclk_p);

      assert (q_empty == 3'b111 && !rx_wr_wait && !rx_rd_wait && !wb_ack)
      else
      begin
         fail_cnt++;
         $display("Reset state wrong: a queue not empty or a wait or ack high");
      end
      cfg_check(`ERX_REG_CTRL, 32'h0);

      // Pass-through, readers stall part way
      cfg_write(`ERX_REG_CTRL, 32'h1);
      fork
         run_frames(150);
         stall_phase();
      join
      wait_drain();
      assert (wait_seen)
      else
      begin
         fail_cnt++;
         $display("No link wait rose while the readers stalled");
      end

      // Page table, two pages land in the response window
      for (int i = 0; i < `ERX_MMU_ENTRIES; i++)
      begin
         ent = $urandom;
         if (i == 8 || i == 12)
            ent[11:0] = `ERX_RR_ID;
         cfg_write(`ERX_REG_TABLE_BASE + i, ent);
      end
      for (int i = 0; i < `ERX_MMU_ENTRIES; i++)
         cfg_check(`ERX_REG_TABLE_BASE + i, data_t'(model_tbl[i]));
      cfg_write(`ERX_REG_CTRL, 32'h3);
      cfg_check(`ERX_REG_CTRL, 32'h3);
      run_frames(150);
      wait_drain();

      // Receive disabled
      cfg_write(`ERX_REG_CTRL, 32'h0);
      run_frames(N_FRAMES - 300);
      repeat (20) @(negedge rxlclk_p);
      assert (q_empty == 3'b111)
      else
      begin
         fail_cnt++;
         $display("A queue received a transaction while receive was disabled");
      end
      wait_drain();

      $display("Summary: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
      if (mismatch_cnt + fail_cnt == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog timeout: the test did not finish by %0t", $time);
      $display("Summary: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/erx_pkg.sv
source/erx_beat_counter.sv
source/erx_protocol_fsm.sv
source/erx_cfg_mmu.sv
source/erx_disty.sv
source/erx_fifo.sv
source/erx.sv
dv/erx_sva.sv
dv/erx_tb.sv

//--- source/erx.sv
`timescale 1ns/1ps
`default_nettype none

module erx
(
   input  wire                  rxlclk_p,  // Link clock, whole design
   input  wire                  arst_n,
   // Link side
   input  wire                  rx_frame,
   input  wire  [7:0]           rx_data,
   output logic                 rx_wr_wait,
   output logic                 rx_rd_wait,
   // Configuration bus
   input  wire erx_pkg::wb_req_t     wb_req,
   output erx_pkg::data_t       wb_dat_r,
   output logic                 wb_ack,
   // Write queue
   input  wire                  wr_rd_en,
   output logic                 wr_empty,
   output erx_pkg::emesh_pkt_t  wr_rd_data,
   // Read request queue
   input  wire                  rq_rd_en,
   output logic                 rq_empty,
   output erx_pkg::emesh_pkt_t  rq_rd_data,
   // Read response queue
   input  wire                  rr_rd_en,
   output logic                 rr_empty,
   output erx_pkg::emesh_pkt_t  rr_rd_data
);

   import erx_pkg::*;

   logic [3:0] beat_idx;
   logic       last_beat;
   emesh_pkt_t rx_pkt;                     // Assembled frame
   logic       rx_valid;
   emesh_pkt_t mmu_pkt;                    // After translation
   logic       mmu_valid;
   logic       rx_enable;
   emesh_pkt_t q_wr_data;                  // Shared queue write data
   logic       wr_wr_en, rq_wr_en, rr_wr_en;
   logic       wr_full, rq_full, rr_full;
   logic       wr_prog_full, rq_prog_full, rr_prog_full;

   erx_beat_counter u_beat_counter (
      .rxlclk_p (rxlclk_p), .arst_n (arst_n), .frame (rx_frame),
      .beat_idx (beat_idx), .last_beat (last_beat));

   erx_protocol_fsm u_protocol_fsm (
      .rxlclk_p (rxlclk_p), .arst_n (arst_n), .rx_frame (rx_frame), .rx_data (rx_data),
      .beat_idx (beat_idx), .last_beat (last_beat), .rx_pkt (rx_pkt), .rx_valid (rx_valid));

   erx_cfg_mmu u_cfg_mmu (
      .rxlclk_p (rxlclk_p), .arst_n (arst_n), .wb_req (wb_req), .wb_dat_r (wb_dat_r),
      .wb_ack (wb_ack), .rx_pkt (rx_pkt), .rx_valid (rx_valid), .mmu_pkt (mmu_pkt),
      .mmu_valid (mmu_valid), .rx_enable (rx_enable));

   erx_disty u_disty (
      .rxlclk_p (rxlclk_p), .arst_n (arst_n), .mmu_pkt (mmu_pkt), .mmu_valid (mmu_valid),
      .rx_enable (rx_enable), .wr_wr_en (wr_wr_en), .rq_wr_en (rq_wr_en),
      .rr_wr_en (rr_wr_en), .wr_data (q_wr_data),
      .wr_full (wr_full), .wr_prog_full (wr_prog_full),
      .rq_full (rq_full), .rq_prog_full (rq_prog_full),
      .rr_full (rr_full), .rr_prog_full (rr_prog_full),
      .rx_wr_wait (rx_wr_wait), .rx_rd_wait (rx_rd_wait));

   // Writes to the mesh
   erx_fifo u_wr_fifo (
      .rxlclk_p (rxlclk_p), .arst_n (arst_n), .wr_en (wr_wr_en), .din (q_wr_data),
      .full (wr_full), .prog_full (wr_prog_full), .rd_en (wr_rd_en),
      .empty (wr_empty), .dout (wr_rd_data));

   // Read requests
   erx_fifo u_rq_fifo (
      .rxlclk_p (rxlclk_p), .arst_n (arst_n), .wr_en (rq_wr_en), .din (q_wr_data),
      .full (rq_full), .prog_full (rq_prog_full), .rd_en (rq_rd_en),
      .empty (rq_empty), .dout (rq_rd_data));

   // Read responses
   erx_fifo u_rr_fifo (
      .rxlclk_p (rxlclk_p), .arst_n (arst_n), .wr_en (rr_wr_en), .din (q_wr_data),
      .full (rr_full), .prog_full (rr_prog_full), .rd_en (rr_rd_en),
      .empty (rr_empty), .dout (rr_rd_data));

endmodule

`default_nettype wire

//--- source/erx_beat_counter.sv
`timescale 1ns/1ps
`default_nettype none
`include "erx_consts.svh"

module erx_beat_counter
(
   input  wire        rxlclk_p,
   input  wire        arst_n,
   input  wire        frame,             // Link frame bit
   output logic [3:0] beat_idx,          // Byte number within the frame
   output logic       last_beat          // Final byte on the link now
);

   localparam logic [3:0] LAST_IDX = 4'(`ERX_FRAME_BYTES - 1);

   logic [3:0] beat_cnt;                 // Beats seen in this frame

   always_ff @(posedge rxlclk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         beat_cnt <= '0;
      end
      else if (!frame)
      begin
         beat_cnt <= '0;                 // Gap or abort restarts framing
      end
      else if (beat_cnt == LAST_IDX)
      begin
         beat_cnt <= '0;                 // Back-to-back frame follows
      end
      else
      begin
         beat_cnt <= beat_cnt + 4'd1;
      end
   end

   assign beat_idx  = beat_cnt;
   assign last_beat = frame & (beat_cnt == LAST_IDX); // Only valid while framed

endmodule

`default_nettype wire

//--- source/erx_cfg_mmu.sv
`timescale 1ns/1ps
`default_nettype none
`include "erx_consts.svh"

module erx_cfg_mmu
(
   input  wire                 rxlclk_p,
   input  wire                 arst_n,
   input  wire erx_pkg::wb_req_t    wb_req,   // Wishbone request
   output erx_pkg::data_t      wb_dat_r,  // Read data with ack
   output logic                wb_ack,
   input  wire erx_pkg::emesh_pkt_t rx_pkt,   // From protocol FSM
   input  wire                 rx_valid,
   output erx_pkg::emesh_pkt_t mmu_pkt,   // Translated transaction
   output logic                mmu_valid,
   output logic                rx_enable  // Receive enable bit
);

   import erx_pkg::*;

   localparam int TBL_AW = $clog2(`ERX_MMU_ENTRIES);

   logic              cfg_mmu_mode;       // Translation on
   page_t             page_tbl [`ERX_MMU_ENTRIES]; // Page per top nibble
   logic              wb_accept;          // New request this cycle
   logic              hit_ctrl;
   logic              hit_tbl;
   wb_adr_t           tbl_off;            // Offset into table window
   logic [TBL_AW-1:0] tbl_idx;
   data_t             rd_word;            // Read mux result
   emesh_pkt_t        xlat_pkt;           // Translated, before the flop

   assign wb_accept = wb_req.cyc & wb_req.stb & ~wb_ack; // One ack per request
   assign hit_ctrl  = (wb_req.adr == wb_adr_t'(`ERX_REG_CTRL));
   assign hit_tbl   = (wb_req.adr >= wb_adr_t'(`ERX_REG_TABLE_BASE));
   assign tbl_off   = wb_req.adr - wb_adr_t'(`ERX_REG_TABLE_BASE);
   assign tbl_idx   = tbl_off[TBL_AW-1:0];

   always_ff @(posedge rxlclk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wb_ack       <= 1'b0;
         rx_enable    <= 1'b0;
         cfg_mmu_mode <= 1'b0;
         for (int i = 0; i < `ERX_MMU_ENTRIES; i++)
            page_tbl[i] <= '0;
      end
      else
      begin
         wb_ack <= wb_accept;
         if (wb_accept && wb_req.we)
         begin
            if (hit_ctrl)
            begin
               rx_enable    <= wb_req.dat_w[`ERX_CTRL_ENABLE_BIT];
               cfg_mmu_mode <= wb_req.dat_w[`ERX_CTRL_MMU_BIT];
            end
            else if (hit_tbl)
            begin
               page_tbl[tbl_idx] <= wb_req.dat_w[11:0]; // Upper bits dropped
            end
         end
      end
   end

   // Unmapped words read back zero
   always_comb
   begin
      rd_word = '0;
      if (hit_ctrl)
      begin
         rd_word[`ERX_CTRL_ENABLE_BIT] = rx_enable;
         rd_word[`ERX_CTRL_MMU_BIT]    = cfg_mmu_mode;
      end
      else if (hit_tbl)
      begin
         rd_word = data_t'(page_tbl[tbl_idx]);
      end
   end

   always_ff @(posedge rxlclk_p)
   begin
      if (wb_accept)
         wb_dat_r <= rd_word;             // Lines up with ack
   end

   // Page swap keeps the low 20 address bits
   always_comb
   begin
      xlat_pkt = rx_pkt;
      if (cfg_mmu_mode)
         xlat_pkt.dstaddr = {page_tbl[rx_pkt.dstaddr[31 -: TBL_AW]], rx_pkt.dstaddr[19:0]};
   end

   always_ff @(posedge rxlclk_p or negedge arst_n)
   begin
      if (!arst_n)
         mmu_valid <= 1'b0;
      else
         mmu_valid <= rx_valid;
   end

   always_ff @(posedge rxlclk_p)
   begin
      if (rx_valid)
         mmu_pkt <= xlat_pkt;
   end

endmodule

`default_nettype wire

//--- source/erx_consts.svh
`ifndef ERX_CONSTS_SVH
`define ERX_CONSTS_SVH

// Link framing
`define ERX_FRAME_BYTES       13         // Ctrl + dstaddr + data + srcaddr bytes

// Queue sizing
`define ERX_FIFO_DEPTH        16         // Words per queue
`define ERX_PROG_MARGIN       4          // Covers frames still in flight

// Address translation
`define ERX_MMU_ENTRIES       16         // One entry per dstaddr[31:28] value
`define ERX_RR_ID             12'h810    // Top page of read responses

// Wishbone register map, word addresses
`define ERX_REG_CTRL          0          // Control register
`define ERX_REG_TABLE_BASE    16         // First page table entry

// Control register bits
`define ERX_CTRL_ENABLE_BIT   0          // Receive enable
`define ERX_CTRL_MMU_BIT      1          // Translation on

`endif

//--- source/erx_disty.sv
`timescale 1ns/1ps
`default_nettype none
`include "erx_consts.svh"

module erx_disty
(
   input  wire                 rxlclk_p,
   input  wire                 arst_n,
   input  wire erx_pkg::emesh_pkt_t mmu_pkt, // Translated transaction
   input  wire                 mmu_valid,
   input  wire                 rx_enable,    // Drop all when low
   output logic                wr_wr_en,     // Write queue push
   output logic                rq_wr_en,     // Read request queue push
   output logic                rr_wr_en,     // Read response queue push
   output erx_pkg::emesh_pkt_t wr_data,      // Common to all queues
   input  wire                 wr_full,
   input  wire                 wr_prog_full,
   input  wire                 rq_full,
   input  wire                 rq_prog_full,
   input  wire                 rr_full,
   input  wire                 rr_prog_full,
   output logic                rx_wr_wait,   // Back-pressure for writes
   output logic                rx_rd_wait    // Back-pressure for reads
);

   import erx_pkg::*;

   page_t dst_page;                      // Page after translation
   logic  take;                          // Transaction to deliver
   logic  is_rq;
   logic  is_rr;
   logic  is_wr;

   assign dst_page = mmu_pkt.dstaddr[31:20];
   assign take     = mmu_valid & rx_enable;
   assign is_rq    = ~mmu_pkt.write;
   assign is_rr    = mmu_pkt.write & (dst_page == `ERX_RR_ID); // Response window
   assign is_wr    = mmu_pkt.write & ~is_rr;

   always_ff @(posedge rxlclk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_wr_en   <= 1'b0;
         rq_wr_en   <= 1'b0;
         rr_wr_en   <= 1'b0;
         rx_wr_wait <= 1'b0;
         rx_rd_wait <= 1'b0;
      end
      else
      begin
         wr_wr_en   <= take & is_wr & ~wr_full; // Full queue loses the word
         rq_wr_en   <= take & is_rq & ~rq_full;
         rr_wr_en   <= take & is_rr & ~rr_full;
         rx_wr_wait <= wr_prog_full | rr_prog_full; // Both carry write frames
         rx_rd_wait <= rq_prog_full;
      end
   end

   always_ff @(posedge rxlclk_p)
   begin
      if (mmu_valid)
         wr_data <= mmu_pkt;
   end

endmodule

`default_nettype wire

//--- source/erx_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "erx_consts.svh"

module erx_fifo
#(
   parameter int DEPTH = `ERX_FIFO_DEPTH  // Power of two
)
(
   input  wire                 rxlclk_p,
   input  wire                 arst_n,
   input  wire                 wr_en,
   input  wire erx_pkg::emesh_pkt_t din,
   output logic                full,
   output logic                prog_full, // Near full, sender must wait
   input  wire                 rd_en,
   output logic                empty,
   output erx_pkg::emesh_pkt_t dout       // Head word, valid when not empty
);

   import erx_pkg::*;

   localparam int             AW       = $clog2(DEPTH);
   localparam logic [AW:0]    FULL_CNT = (AW+1)'(DEPTH);
   localparam logic [AW:0]    PF_CNT   = (AW+1)'(DEPTH - `ERX_PROG_MARGIN);

   emesh_pkt_t    mem [DEPTH];            // Storage array
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;                  // Words held
   logic          do_wr;
   logic          do_rd;

   assign do_wr     = wr_en & ~full;      // Overflow is ignored
   assign do_rd     = rd_en & ~empty;     // Underflow is ignored
   assign full      = (count == FULL_CNT);
   assign empty     = (count == '0);
   assign prog_full = (count >= PF_CNT);
   assign dout      = mem[rd_ptr];        // Fall-through read

   always_ff @(posedge rxlclk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;      // Wraps at DEPTH
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;      // Idle or push and pop
         endcase
      end
   end

   always_ff @(posedge rxlclk_p)
   begin
      if (do_wr)
         mem[wr_ptr] <= din;
   end

endmodule

`default_nettype wire

//--- source/erx_pkg.sv
`default_nettype none

package erx_pkg;

   typedef logic [31:0] addr_t;          // Mesh address
   typedef logic [31:0] data_t;          // Mesh data word
   typedef logic [3:0]  ctrlmode_t;      // Transaction control mode
   typedef logic [1:0]  datamode_t;      // Access size
   typedef logic [11:0] page_t;          // Translated page number
   typedef logic [4:0]  wb_adr_t;        // Wishbone word address

   // One queue word, 103 bits
   typedef struct packed
   {
      logic      write;                  // 1 = write, 0 = read request
      datamode_t datamode;
      ctrlmode_t ctrlmode;
      addr_t     dstaddr;
      data_t     data;
      addr_t     srcaddr;
   } emesh_pkt_t;

   // Wishbone classic request side
   typedef struct packed
   {
      logic    cyc;
      logic    stb;
      logic    we;
      wb_adr_t adr;
      data_t   dat_w;
   } wb_req_t;

   // Frame assembly FSM
   typedef enum logic [1:0]
   {
      RX_IDLE,                           // Waiting for a control byte
      RX_BODY,                           // Inside a frame
      RX_DROP                            // Frame fell early
   } rx_state_t;

endpackage

`default_nettype wire

//--- source/erx_protocol_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module erx_protocol_fsm
(
   input  wire                 rxlclk_p,
   input  wire                 arst_n,
   input  wire                 rx_frame,  // Link frame bit
   input  wire  [7:0]          rx_data,   // Link byte
   input  wire  [3:0]          beat_idx,  // From beat counter
   input  wire                 last_beat, // From beat counter
   output erx_pkg::emesh_pkt_t rx_pkt,    // Completed transaction
   output logic                rx_valid   // One cycle per good frame
);

   import erx_pkg::*;

   rx_state_t  state;                     // Current FSM state
   rx_state_t  state_nxt;
   emesh_pkt_t asm_pkt;                   // Transaction being assembled
   logic       pkt_done;                  // Final byte taken last edge

   always_comb
   begin
      state_nxt = state;
      case (state)
         RX_IDLE, RX_DROP:
         begin
            // Counter is at zero here, so a high frame is a control byte
            state_nxt = rx_frame ? RX_BODY : RX_IDLE;
         end
         RX_BODY:
         begin
            if (!rx_frame)
               state_nxt = RX_DROP;       // Short frame, throw away
            else if (last_beat)
               state_nxt = RX_IDLE;
         end
         default:
         begin
            state_nxt = RX_IDLE;
         end
      endcase
   end

   always_ff @(posedge rxlclk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state    <= RX_IDLE;
         pkt_done <= 1'b0;
         rx_valid <= 1'b0;
      end
      else
      begin
         state    <= state_nxt;
         pkt_done <= (state == RX_BODY) & last_beat; // Aborts never get here
         rx_valid <= pkt_done;
      end
   end

   // Byte shifter, fields picked by beat number
   always_ff @(posedge rxlclk_p)
   begin
      if (rx_frame)
      begin
         case (beat_idx) inside
            4'd0:
            begin
               asm_pkt.write    <= rx_data[7];
               asm_pkt.datamode <= rx_data[6:5];
               asm_pkt.ctrlmode <= rx_data[3:0]; // Bit 4 unused
            end
            [4'd1:4'd4]:  asm_pkt.dstaddr <= {asm_pkt.dstaddr[23:0], rx_data}; // MSB first
            [4'd5:4'd8]:  asm_pkt.data    <= {asm_pkt.data[23:0], rx_data};
            [4'd9:4'd12]: asm_pkt.srcaddr <= {asm_pkt.srcaddr[23:0], rx_data};
            default:      ;
         endcase
      end
      if (pkt_done)
         rx_pkt <= asm_pkt;               // Safe against next ctrl byte
   end

endmodule

`default_nettype wire
